//--- run_sim.sh
#!/bin/sh
# build and run the testbench; a $fatal gives a non-zero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f src.f \
    --top-module tb_mips_cpu \
    -o tb_mips_cpu

./obj_dir/tb_mips_cpu

//--- source/mips_alu.sv
`default_nettype none
`include "mips_defines.svh"

module mips_alu import mips_pkg::*; (
    input  word_t         op_a,
    input  word_t         op_b,
    input  instr_fields_t instr,
    output alu_out_t      alu_out
);

    word_t imm_sext;
    word_t imm_zext;
    logic signed [63:0] prod_s;
    logic [63:0] prod_u;

    // immediate is the low half of the instruction word
    assign imm_sext = {{16{instr.rd[4]}}, instr.rd, instr.shamt, instr.funct};
    assign imm_zext = {16'h0000, instr.rd, instr.shamt, instr.funct};

    assign prod_s = $signed({{32{op_a[31]}}, op_a}) * $signed({{32{op_b[31]}}, op_b});
    assign prod_u = {32'h0, op_a} * {32'h0, op_b};

    // base plus offset for every load and store
    assign alu_out.eff_addr = op_a + imm_sext;

    always_comb begin
        alu_out.result = '0;
        case (instr.opcode)
            `MIPS_OP_SPECIAL: begin
                case (instr.funct)
                    `MIPS_FN_SLL:  alu_out.result = op_b << instr.shamt;
                    `MIPS_FN_SRL:  alu_out.result = op_b >> instr.shamt;
                    `MIPS_FN_SRA:  alu_out.result = $signed(op_b) >>> instr.shamt;
                    `MIPS_FN_SLLV: alu_out.result = op_b << op_a[4:0];
                    `MIPS_FN_SRLV: alu_out.result = op_b >> op_a[4:0];
                    `MIPS_FN_SRAV: alu_out.result = $signed(op_b) >>> op_a[4:0];
                    // no overflow trap, add and sub wrap
                    `MIPS_FN_ADD,
                    `MIPS_FN_ADDU: alu_out.result = op_a + op_b;
                    `MIPS_FN_SUB,
                    `MIPS_FN_SUBU: alu_out.result = op_a - op_b;
                    `MIPS_FN_AND:  alu_out.result = op_a & op_b;
                    `MIPS_FN_OR:   alu_out.result = op_a | op_b;
                    `MIPS_FN_XOR:  alu_out.result = op_a ^ op_b;
                    `MIPS_FN_NOR:  alu_out.result = ~(op_a | op_b);
                    `MIPS_FN_SLT:  alu_out.result = {31'h0, $signed(op_a) < $signed(op_b)};
                    `MIPS_FN_SLTU: alu_out.result = {31'h0, op_a < op_b};
                    default:       alu_out.result = '0;
                endcase
            end
            `MIPS_OP_ADDI,
            `MIPS_OP_ADDIU: alu_out.result = op_a + imm_sext;
            `MIPS_OP_SLTI:  alu_out.result = {31'h0, $signed(op_a) < $signed(imm_sext)};
            `MIPS_OP_SLTIU: alu_out.result = {31'h0, op_a < imm_sext};
            `MIPS_OP_ANDI:  alu_out.result = op_a & imm_zext;
            `MIPS_OP_ORI:   alu_out.result = op_a | imm_zext;
            `MIPS_OP_XORI:  alu_out.result = op_a ^ imm_zext;
            `MIPS_OP_LUI:   alu_out.result = {imm_zext[15:0], 16'h0000};
            default:        alu_out.result = '0;
        endcase
    end

    // hi/lo candidates, the core decides which half is written
    always_comb begin
        case (instr.funct)
            `MIPS_FN_MULT: begin
                alu_out.hi = prod_s[63:32];
                alu_out.lo = prod_s[31:0];
            end
            `MIPS_FN_MULTU: begin
                alu_out.hi = prod_u[63:32];
                alu_out.lo = prod_u[31:0];
            end
            default: begin
                // mthi and mtlo
                alu_out.hi = op_a;
                alu_out.lo = op_a;
            end
        endcase
    end

    always_comb begin
        case (instr.opcode)
            `MIPS_OP_BEQ:  alu_out.branch_taken = (op_a == op_b);
            `MIPS_OP_BNE:  alu_out.branch_taken = (op_a != op_b);
            `MIPS_OP_BLEZ: alu_out.branch_taken = op_a[31] || (op_a == '0);
            `MIPS_OP_BGTZ: alu_out.branch_taken = !op_a[31] && (op_a != '0);
            `MIPS_OP_REGIMM: begin
                case (instr.rt)
                    `MIPS_RT_BLTZ,
                    `MIPS_RT_BLTZAL: alu_out.branch_taken = op_a[31];
                    `MIPS_RT_BGEZ,
                    `MIPS_RT_BGEZAL: alu_out.branch_taken = !op_a[31];
                    default:         alu_out.branch_taken = 1'b0;
                endcase
            end
            default: alu_out.branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/mips_cpu_harvard.sv
`default_nettype none
`include "mips_defines.svh"

module mips_cpu_harvard import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  clk_enable,
    output logic  active,
    output word_t register_v0,
    output word_t instr_address,
    input  word_t instr_readdata,
    output word_t data_address,
    output logic  data_write,
    output logic  data_read,
    output word_t data_writedata,
    input  word_t data_readdata
);

    instr_fields_t instr;
    cpu_state_t    state;
    word_t         pc;
    word_t         delay_slot;
    word_t         next_addr;
    word_t         branch_offset;
    word_t         hi_q;
    word_t         lo_q;
    word_t         rs_data;
    word_t         rt_data;
    word_t         load_word;
    word_t         wb_data;
    reg_index_t    wb_index;
    alu_out_t      alu_out;
    logic          exec_now;

    // decoded controls
    logic is_load;
    logic is_store;
    logic is_partial_store;
    logic reg_write;
    logic dest_rd;
    logic link_const;
    logic link_reg;
    logic jump_imm;
    logic jump_reg;
    logic hi_write;
    logic lo_write;
    logic sel_hi;
    logic sel_lo;

    assign instr = instr_fields_t'(instr_readdata);

    always_comb begin
        is_load = 1'b0;
        is_store = 1'b0;
        is_partial_store = 1'b0;
        reg_write = 1'b0;
        dest_rd = 1'b0;
        link_const = 1'b0;
        link_reg = 1'b0;
        jump_imm = 1'b0;
        jump_reg = 1'b0;
        hi_write = 1'b0;
        lo_write = 1'b0;
        sel_hi = 1'b0;
        sel_lo = 1'b0;
        case (instr.opcode)
            `MIPS_OP_SPECIAL: begin
                dest_rd = 1'b1;
                case (instr.funct)
                    `MIPS_FN_JR:    jump_reg = 1'b1;
                    `MIPS_FN_JALR: begin
                        jump_reg = 1'b1;
                        link_reg = 1'b1;
                        reg_write = 1'b1;
                    end
                    `MIPS_FN_MULT,
                    `MIPS_FN_MULTU: begin
                        hi_write = 1'b1;
                        lo_write = 1'b1;
                    end
                    `MIPS_FN_MTHI:  hi_write = 1'b1;
                    `MIPS_FN_MTLO:  lo_write = 1'b1;
                    `MIPS_FN_MFHI: begin
                        sel_hi = 1'b1;
                        reg_write = 1'b1;
                    end
                    `MIPS_FN_MFLO: begin
                        sel_lo = 1'b1;
                        reg_write = 1'b1;
                    end
                    `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA,
                    `MIPS_FN_SLLV, `MIPS_FN_SRLV, `MIPS_FN_SRAV,
                    `MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB, `MIPS_FN_SUBU,
                    `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_NOR,
                    `MIPS_FN_SLT, `MIPS_FN_SLTU: reg_write = 1'b1;
                    default: reg_write = 1'b0;
                endcase
            end
            // bltzal and bgezal link whether taken or not
            `MIPS_OP_REGIMM: begin
                link_const = instr.rt == `MIPS_RT_BLTZAL || instr.rt == `MIPS_RT_BGEZAL;
                reg_write = link_const;
            end
            `MIPS_OP_J: jump_imm = 1'b1;
            `MIPS_OP_JAL: begin
                jump_imm = 1'b1;
                link_const = 1'b1;
                reg_write = 1'b1;
            end
            `MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU,
            `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI: begin
                reg_write = 1'b1;
            end
            `MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW, `MIPS_OP_LBU, `MIPS_OP_LHU: begin
                is_load = 1'b1;
                reg_write = 1'b1;
            end
            `MIPS_OP_SB,
            `MIPS_OP_SH: begin
                is_store = 1'b1;
                is_partial_store = 1'b1;
            end
            `MIPS_OP_SW: is_store = 1'b1;
            default: reg_write = 1'b0;
        endcase
    end

    assign exec_now = active && (state == st_exec);

    assign wb_index = link_const ? `MIPS_LINK_REG : (dest_rd ? instr.rd : instr.rt);

    always_comb begin
        if (link_const || link_reg) begin
            wb_data = delay_slot + 32'd4;
        end else if (sel_hi) begin
            wb_data = hi_q;
        end else if (sel_lo) begin
            wb_data = lo_q;
        end else if (is_load) begin
            wb_data = load_word;
        end else begin
            wb_data = alu_out.result;
        end
    end

    mips_regfile i_regfile (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .rd_index_a  (instr.rs),
        .rd_index_b  (instr.rt),
        .rd_data_a   (rs_data),
        .rd_data_b   (rt_data),
        .wr_enable   (exec_now && reg_write),
        .wr_index    (wb_index),
        .wr_data     (wb_data),
        .register_v0 (register_v0)
    );

    mips_alu i_alu (
        .op_a    (rs_data),
        .op_b    (rt_data),
        .instr   (instr),
        .alu_out (alu_out)
    );

    mips_load_align i_load_align (
        .instr     (instr),
        .eff_addr  (alu_out.eff_addr),
        .mem_word  (data_readdata),
        .load_word (load_word)
    );

    mips_store_align i_store_align (
        .instr      (instr),
        .eff_addr   (alu_out.eff_addr),
        .reg_word   (rt_data),
        .mem_word   (data_readdata),
        .store_word (data_writedata)
    );

    always_ff @(posedge clk) begin
        if (clk_enable && exec_now) begin
            if (hi_write) begin
                hi_q <= alu_out.hi;
            end
            if (lo_write) begin
                lo_q <= alu_out.lo;
            end
        end
    end

    // memory side
    assign data_address = {alu_out.eff_addr[31:2], 2'b00};
    assign data_write = exec_now && is_store;
    // fetch-state read is the first half of sb/sh read-modify-write
    assign data_read = active && (is_load || (is_partial_store && state == st_fetch));

    // branch offset is relative to the delay slot
    assign branch_offset = {{14{instr_readdata[15]}}, instr_readdata[15:0], 2'b00};

    always_comb begin
        if (alu_out.branch_taken) begin
            next_addr = delay_slot + branch_offset;
        end else if (jump_imm) begin
            next_addr = {delay_slot[31:28], instr_readdata[25:0], 2'b00};
        end else if (jump_reg) begin
            next_addr = rs_data;
        end else begin
            // sequential flow continues after the delay slot
            next_addr = delay_slot + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                pc <= `MIPS_RESET_VECTOR;
                delay_slot <= `MIPS_RESET_VECTOR + 32'd4;
                state <= st_fetch;
                active <= 1'b1;
            end else if (active) begin
                case (state)
                    st_fetch: state <= st_exec;
                    default: begin
                        state <= st_fetch;
                        pc <= delay_slot;
                        delay_slot <= next_addr;
                        // the instruction just run was the last one
                        if (delay_slot == `MIPS_HALT_ADDR) begin
                            active <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    assign instr_address = pc;

endmodule

`default_nettype wire

//--- source/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// first fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000
// next-address value that stops the core
`define MIPS_HALT_ADDR 32'h0000_0000
// constant link target of jal, bltzal and bgezal
`define MIPS_LINK_REG 5'd31

// primary opcodes
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_REGIMM 6'h01
`define MIPS_OP_J 6'h02
`define MIPS_OP_JAL 6'h03
`define MIPS_OP_BEQ 6'h04
`define MIPS_OP_BNE 6'h05
`define MIPS_OP_BLEZ 6'h06
`define MIPS_OP_BGTZ 6'h07
`define MIPS_OP_ADDI 6'h08
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_SLTI 6'h0A
`define MIPS_OP_SLTIU 6'h0B
`define MIPS_OP_ANDI 6'h0C
`define MIPS_OP_ORI 6'h0D
`define MIPS_OP_XORI 6'h0E
`define MIPS_OP_LUI 6'h0F
`define MIPS_OP_LB 6'h20
`define MIPS_OP_LH 6'h21
`define MIPS_OP_LW 6'h23
`define MIPS_OP_LBU 6'h24
`define MIPS_OP_LHU 6'h25
`define MIPS_OP_SB 6'h28
`define MIPS_OP_SH 6'h29
`define MIPS_OP_SW 6'h2B

// funct codes of the SPECIAL opcode
`define MIPS_FN_SLL 6'h00
`define MIPS_FN_SRL 6'h02
`define MIPS_FN_SRA 6'h03
`define MIPS_FN_SLLV 6'h04
`define MIPS_FN_SRLV 6'h06
`define MIPS_FN_SRAV 6'h07
`define MIPS_FN_JR 6'h08
`define MIPS_FN_JALR 6'h09
`define MIPS_FN_MFHI 6'h10
`define MIPS_FN_MTHI 6'h11
`define MIPS_FN_MFLO 6'h12
`define MIPS_FN_MTLO 6'h13
`define MIPS_FN_MULT 6'h18
`define MIPS_FN_MULTU 6'h19
`define MIPS_FN_ADD 6'h20
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUB 6'h22
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND 6'h24
`define MIPS_FN_OR 6'h25
`define MIPS_FN_XOR 6'h26
`define MIPS_FN_NOR 6'h27
`define MIPS_FN_SLT 6'h2A
`define MIPS_FN_SLTU 6'h2B

// rt codes of the REGIMM branches
`define MIPS_RT_BLTZ 5'h00
`define MIPS_RT_BGEZ 5'h01
`define MIPS_RT_BLTZAL 5'h10
`define MIPS_RT_BGEZAL 5'h11

`endif

//--- source/mips_load_align.sv
`default_nettype none
`include "mips_defines.svh"

module mips_load_align import mips_pkg::*; (
    input  instr_fields_t instr,
    input  word_t         eff_addr,
    input  word_t         mem_word,
    output word_t         load_word
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // big-endian, lane 0 is the top byte
    always_comb begin
        case (eff_addr[1:0])
            2'd0:    byte_val = mem_word[31:24];
            2'd1:    byte_val = mem_word[23:16];
            2'd2:    byte_val = mem_word[15:8];
            default: byte_val = mem_word[7:0];
        endcase
    end

    assign half_val = eff_addr[1] ? mem_word[15:0] : mem_word[31:16];

    always_comb begin
        case (instr.opcode)
            `MIPS_OP_LB:  load_word = {{24{byte_val[7]}}, byte_val};
            `MIPS_OP_LBU: load_word = {24'h0, byte_val};
            `MIPS_OP_LH:  load_word = {{16{half_val[15]}}, half_val};
            `MIPS_OP_LHU: load_word = {16'h0, half_val};
            // lw takes the whole word
            default:      load_word = mem_word;
        endcase
    end

endmodule

`default_nettype wire

//--- source/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // register number
    typedef logic [4:0] reg_index_t;

    // multicycle core: one fetch cycle, one execute cycle
    typedef enum logic {
        st_fetch,
        st_exec
    } cpu_state_t;

    // R-type view of an instruction word
    // immediate and jump target are taken as slices of the raw word
    typedef struct packed {
        logic [5:0] opcode;
        reg_index_t rs;
        reg_index_t rt;
        reg_index_t rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_fields_t;

    typedef struct packed {
        word_t result;
        word_t hi;
        word_t lo;
        word_t eff_addr;
        logic  branch_taken;
    } alu_out_t;

endpackage

`default_nettype wire

//--- source/mips_regfile.sv
`default_nettype none

module mips_regfile import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       clk_enable,
    input  reg_index_t rd_index_a,
    input  reg_index_t rd_index_b,
    output word_t      rd_data_a,
    output word_t      rd_data_b,
    input  logic       wr_enable,
    input  reg_index_t wr_index,
    input  word_t      wr_data,
    output word_t      register_v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                for (int i = 0; i < 32; i++) begin
                    regs[i] <= '0;
                end
            end else if (wr_enable && wr_index != 5'd0) begin
                regs[wr_index] <= wr_data;
            end
        end
    end

    // $zero reads as zero whatever the array holds
    assign rd_data_a = (rd_index_a == 5'd0) ? '0 : regs[rd_index_a];
    assign rd_data_b = (rd_index_b == 5'd0) ? '0 : regs[rd_index_b];

    assign register_v0 = regs[2];

endmodule

`default_nettype wire

//--- source/mips_store_align.sv
`default_nettype none
`include "mips_defines.svh"

module mips_store_align import mips_pkg::*; (
    input  instr_fields_t instr,
    input  word_t         eff_addr,
    input  word_t         reg_word,
    input  word_t         mem_word,
    output word_t         store_word
);

    // partial stores patch one lane of the word read during fetch
    always_comb begin
        store_word = mem_word;
        case (instr.opcode)
            `MIPS_OP_SB: begin
                case (eff_addr[1:0])
                    2'd0:    store_word[31:24] = reg_word[7:0];
                    2'd1:    store_word[23:16] = reg_word[7:0];
                    2'd2:    store_word[15:8] = reg_word[7:0];
                    default: store_word[7:0] = reg_word[7:0];
                endcase
            end
            `MIPS_OP_SH: begin
                if (eff_addr[1]) begin
                    store_word[15:0] = reg_word[15:0];
                end else begin
                    store_word[31:16] = reg_word[15:0];
                end
            end
            default: store_word = reg_word;
        endcase
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/mips_pkg.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_load_align.sv
source/mips_store_align.sv
source/mips_cpu_harvard.sv
verification/tb_clock_gen.sv
verification/tb_mips_cpu.sv

//--- verification/mips_patterns.txt
// block: test number, randomize flag, word count, program words, expected v0
// a test number of FFFFFFFF ends the list
2 0 E
34081234 3C09F000 01095021 000A5903 000A6202 0128682A 0128702B
396FFFFF 01EC1023 018D1804 00431025 2442FFFF 00000008 00000000
FE14FEC9
3 0 13
34040100 3C051122 34A53344 AC850000 340600AB A0860001 34078899
A4870002 8C880000 80890003 908A0001 848B0002 948C0000 01091021
004A1026 004B1021 004C1023 00000008 00000000
11AAFF87
4 0 19
34020001 10000002 24420002 24420100 14000005 24420004 0FF0000C
24420008 27E30018 00602009 24420010 24420200 03E00008 005F1021
00441023 04110002 24420020 24420400 04400002 005F1021 0BF00017
24420040 24420800 00000008 00000000
BFC000B7
5 0 13
3C08FFFF 3508FFFE 34090003 01090018 00005010 00005812 01090019
00006010 01200013 01600011 00006812 00007010 014B1021 004C1026
004D1021 00021100 004E1026 00000008 00000000
0000001A
6 1 E
34081234 3C09F000 01095021 000A5903 000A6202 0128682A 0128702B
396FFFFF 01EC1023 018D1804 00431025 2442FFFF 00000008 00000000
FE14FEC9
7 1 13
34040100 3C051122 34A53344 AC850000 340600AB A0860001 34078899
A4870002 8C880000 80890003 908A0001 848B0002 948C0000 01091021
004A1026 004B1021 004C1023 00000008 00000000
11AAFF87
8 1 19
34020001 10000002 24420002 24420100 14000005 24420004 0FF0000C
24420008 27E30018 00602009 24420010 24420200 03E00008 005F1021
00441023 04110002 24420020 24420400 04400002 005F1021 0BF00017
24420040 24420800 00000008 00000000
BFC000B7
9 1 13
3C08FFFF 3508FFFE 34090003 01090018 00005010 00005812 01090019
00006010 01200013 01600011 00006812 00007010 014B1021 004C1026
004D1021 00021100 004E1026 00000008 00000000
0000001A
FFFFFFFF

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset,
    input  logic reset_start
);

    // reset is high out of time zero, and again after each reset_start
    logic [4:0] reset_count = 5'd16;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_start) begin
            reset_count <= 5'd16;
        end else if (reset_count != 5'd0) begin
            reset_count <= reset_count - 5'd1;
        end
    end

    assign reset = (reset_count != 5'd0);

endmodule

`default_nettype wire

//--- verification/tb_mips_cpu.sv
`default_nettype none
`include "mips_defines.svh"

module tb_mips_cpu import mips_pkg::*; ();

    localparam int PATTERN_WORDS = 256;
    localparam int INSTR_WORDS = 64;
    localparam int HALT_LIMIT = 4000;

    logic  clk;
    logic  reset;
    logic  reset_start = 1'b0;
    logic  clk_enable = 1'b1;
    logic  random_mode = 1'b0;
    logic  exec_phase = 1'b0;
    logic [31:0] lcg_state = 32'h3bfa_6409;
    logic  active;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t instr_offset;
    word_t data_address;
    logic  data_write;
    logic  data_read;
    word_t data_writedata;
    word_t data_readdata;

    word_t patterns [PATTERN_WORDS];
    word_t instr_mem [INSTR_WORDS];
    // 1 KiB of data, one entry per word
    word_t data_mem [256];

    tb_clock_gen i_clock_gen (
        .clk         (clk),
        .reset       (reset),
        .reset_start (reset_start)
    );

    mips_cpu_harvard i_dut (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // instruction memory starts at the reset vector
    assign instr_offset = instr_address - `MIPS_RESET_VECTOR;
    assign instr_readdata = (instr_offset[31:8] == 24'h0) ? instr_mem[instr_offset[7:2]] : '0;
    assign data_readdata = data_mem[data_address[9:2]];

    // cleared under reset, written on enabled edges
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                data_mem[i] <= '0;
            end
        end else if (data_write && clk_enable) begin
            data_mem[data_address[9:2]] <= data_writedata;
        end
    end

    // mirror of the fetch/execute alternation, high in execute
    always @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                exec_phase <= 1'b0;
            end else if (active) begin
                exec_phase <= !exec_phase;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // loads read in both states, sb and sh only in fetch
    function automatic logic expected_data_read(input word_t instr_word, input logic in_exec);
        logic [5:0] opcode;
        logic       reads;
        opcode = instr_word[31:26];
        case (opcode)
            `MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW, `MIPS_OP_LBU, `MIPS_OP_LHU: reads = 1'b1;
            `MIPS_OP_SB, `MIPS_OP_SH: reads = !in_exec;
            default: reads = 1'b0;
        endcase
        return reads;
    endfunction

    // stall about one cycle in four in random mode
    always @(posedge clk) begin
        if (random_mode) begin
            lcg_state <= lcg_next(lcg_state);
            clk_enable <= (lcg_state[31:30] != 2'b00);
        end else begin
            clk_enable <= 1'b1;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic wait_for_reset_release();
        int   cycles;
        logic seen_high;
        cycles = 0;
        seen_high = 1'b0;
        while (!(seen_high && !reset)) begin
            if (cycles == 64) begin
                stop_with_failure("reset was never released");
            end
            @(negedge clk);
            if (reset) begin
                seen_high = 1'b1;
            end
            cycles++;
        end
    endtask

    task automatic wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        do begin
            if (cycles == HALT_LIMIT) begin
                stop_with_failure("the core never halted");
            end
            @(negedge clk);
            cycles++;
            if (active) begin
                check_value(name, word_t'(expected_data_read(instr_readdata, exec_phase)),
                            word_t'(data_read));
            end
        end while (active);
    endtask

    task automatic run_block(input int base, output int next_base);
        int    test_num;
        int    count;
        logic  rand_flag;
        word_t expected;
        string name;
        test_num = int'(patterns[base]);
        rand_flag = patterns[base + 1][0];
        count = int'(patterns[base + 2]);
        if (count > INSTR_WORDS || base + 3 + count >= PATTERN_WORDS) begin
            stop_with_failure("a block of the pattern file is too long");
        end
        expected = patterns[base + 3 + count];
        next_base = base + 4 + count;

        @(posedge clk);
        random_mode <= 1'b0;
        reset_start <= 1'b1;
        @(posedge clk);
        reset_start <= 1'b0;
        for (int i = 0; i < INSTR_WORDS; i++) begin
            instr_mem[i] = (i < count) ? patterns[base + 3 + i] : '0;
        end
        wait_for_reset_release();

        // one enabled cycle out of reset, still fetching the first word
        @(negedge clk);
        name = $sformatf("test %0d reset", test_num);
        check_value(name, 32'd1, word_t'(active));
        check_value(name, `MIPS_RESET_VECTOR, instr_address);
        check_value(name, 32'd0, word_t'(data_write));

        @(posedge clk);
        random_mode <= rand_flag;
        name = $sformatf("test %0d data_read", test_num);
        wait_for_halt(name);
        check_value($sformatf("test %0d v0", test_num), expected, register_v0);

        name = $sformatf("test %0d after halt", test_num);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value(name, 32'd0, word_t'(data_write));
            check_value(name, 32'd0, word_t'(data_read));
            check_value(name, 32'd0, word_t'(active));
        end
    endtask

    initial begin
        int ptr;
        int next_ptr;
        int tests_run;
        ptr = 0;
        tests_run = 0;
        for (int i = 0; i < INSTR_WORDS; i++) begin
            instr_mem[i] = '0;
        end
        for (int i = 0; i < PATTERN_WORDS; i++) begin
            patterns[i] = 32'hFFFF_FFFF;
        end
        $readmemh("verification/mips_patterns.txt", patterns);
        while (ptr < PATTERN_WORDS && patterns[ptr] != 32'hFFFF_FFFF) begin
            run_block(ptr, next_ptr);
            ptr = next_ptr;
            tests_run++;
        end
        if (tests_run == 0) begin
            stop_with_failure("the pattern file holds no tests");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
